// ==== include/mdu_consts.svh ====
`ifndef MDU_CONSTS_SVH
`define MDU_CONSTS_SVH

// datapath width
`define MDU_XLEN 32

// funct3 width
`define MDU_OP_W 3

// iteration counter, wide enough for XLEN
`define MDU_CNT_W 6

// quotient for a zero divisor
`define MDU_ALL_ONES {`MDU_XLEN{1'b1}}

// most negative integer
`define MDU_INT_MIN {1'b1, {(`MDU_XLEN-1){1'b0}}}

`endif

// ==== src/mdu_pkg.sv ====
`include "mdu_consts.svh"

package mdu_pkg;

  // RISC-V M extension funct3 codes, msb set for divides
  typedef enum logic [`MDU_OP_W-1:0] {
    OP_MUL    = 3'b000,
    OP_MULH   = 3'b001,
    OP_MULHSU = 3'b010,
    OP_MULHU  = 3'b011,
    OP_DIV    = 3'b100,
    OP_DIVU   = 3'b101,
    OP_REM    = 3'b110,
    OP_REMU   = 3'b111
  } mdu_op_e;

  typedef enum logic [2:0] {
    IDLE = 3'd0,
    LOAD = 3'd1,
    RUN  = 3'd2,
    FIX  = 3'd3,
    DONE = 3'd4
  } mdu_state_e;

  typedef struct packed {
    mdu_op_e               op;
    logic [`MDU_XLEN-1:0]  rs1; // multiplicand / dividend
    logic [`MDU_XLEN-1:0]  rs2; // multiplier / divisor
  } mdu_req_t;

  typedef struct packed {
    logic [`MDU_XLEN-1:0]  mag_a;
    logic [`MDU_XLEN-1:0]  mag_b;
    logic                  neg_main; // negate product or quotient
    logic                  neg_rem;  // negate remainder
    logic                  is_div;
    logic                  div_by_zero;
    logic                  div_overflow;
  } mdu_operands_t;

endpackage

// ==== src/mdu_mul_core.sv ====
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_mul_core (
  input  logic                   clk,
  input  logic                   load_i,
  input  logic                   step_i,
  input  logic [`MDU_XLEN-1:0]   mag_a_i,
  input  logic [`MDU_XLEN-1:0]   mag_b_i,
  output logic [2*`MDU_XLEN-1:0] product_o
);

  // upper half is the partial sum, lower half shifts the multiplier out
  logic [2*`MDU_XLEN-1:0] acc_q;
  logic [`MDU_XLEN:0]     sum;
  logic [`MDU_XLEN-1:0]   addend;

  assign addend = acc_q[0] ? mag_a_i : '0;
  assign sum    = {1'b0, acc_q[2*`MDU_XLEN-1:`MDU_XLEN]} + {1'b0, addend};

  always_ff @(posedge clk) begin
    if (load_i) begin
      acc_q <= {{`MDU_XLEN{1'b0}}, mag_b_i};
    end else if (step_i) begin
      acc_q <= {sum, acc_q[`MDU_XLEN-1:1]}; // carry shifts into the top
    end
  end

  assign product_o = acc_q;

endmodule

// ==== src/mdu_div_core.sv ====
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_div_core (
  input  logic                 clk,
  input  logic                 load_i,
  input  logic                 step_i,
  input  logic [`MDU_XLEN-1:0] mag_a_i,
  input  logic [`MDU_XLEN-1:0] mag_b_i,
  output logic [`MDU_XLEN-1:0] quot_o,
  output logic [`MDU_XLEN-1:0] rem_o
);

  logic [`MDU_XLEN-1:0] rem_q;
  logic [`MDU_XLEN-1:0] quot_q;  // dividend bits out, quotient bits in
  logic [`MDU_XLEN:0]   shifted;
  logic [`MDU_XLEN:0]   trial;
  logic                 fits;

  assign shifted = {rem_q, quot_q[`MDU_XLEN-1]};
  assign trial   = shifted - {1'b0, mag_b_i};
  assign fits    = ~trial[`MDU_XLEN]; // no borrow

  always_ff @(posedge clk) begin
    if (load_i) begin
      rem_q  <= '0;
      quot_q <= mag_a_i;
    end else if (step_i) begin
      quot_q <= {quot_q[`MDU_XLEN-2:0], fits};
      if (fits) begin
        rem_q <= trial[`MDU_XLEN-1:0];
      end else begin
        rem_q <= shifted[`MDU_XLEN-1:0]; // restore
      end
    end
  end

  assign quot_o = quot_q;
  assign rem_o  = rem_q;

  // after the final step the unit sits in FIX with a settled remainder
  a_rem_below_divisor: assert property (
    @(posedge clk) (step_i ##1 (!step_i && mag_b_i != '0)) |-> (rem_q < mag_b_i)
  );

endmodule

// ==== src/mdu_operand_prep.sv ====
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_operand_prep import mdu_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start_i,
  input  mdu_req_t      req_i,
  output mdu_operands_t ops_o
);

  mdu_req_t req_q;
  logic     a_signed;
  logic     b_signed;
  logic     sign_a;
  logic     sign_b;
  logic     is_div;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q <= '0;
    end else if (start_i) begin
      req_q <= req_i;
    end
  end

  // which operands the op treats as signed
  always_comb begin
    a_signed = 1'b0;
    b_signed = 1'b0;
    case (req_q.op)
      OP_MULH, OP_DIV, OP_REM: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      OP_MULHSU: a_signed = 1'b1;
      default: ;
    endcase
  end

  assign is_div = req_q.op[`MDU_OP_W-1]; // funct3 msb
  assign sign_a = a_signed & req_q.rs1[`MDU_XLEN-1];
  assign sign_b = b_signed & req_q.rs2[`MDU_XLEN-1];

  always_comb begin
    ops_o.mag_a        = sign_a ? -req_q.rs1 : req_q.rs1;
    ops_o.mag_b        = sign_b ? -req_q.rs2 : req_q.rs2;
    ops_o.neg_main     = sign_a ^ sign_b;
    ops_o.neg_rem      = is_div & sign_a; // remainder follows dividend
    ops_o.is_div       = is_div;
    ops_o.div_by_zero  = is_div & (req_q.rs2 == '0);
    // only signed divides can overflow
    ops_o.div_overflow = is_div & b_signed & (req_q.rs1 == `MDU_INT_MIN) &
                         (req_q.rs2 == `MDU_ALL_ONES);
  end

endmodule

// ==== src/mdu_ctrl.sv ====
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_ctrl import mdu_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          valid_i,
  input  mdu_operands_t ops_i,
  output logic          start_o,
  output logic          load_o,
  output logic          step_o,
  output logic          fix_en_o,
  output mdu_state_e    state_o,
  output logic          done_o
);

  localparam logic [`MDU_CNT_W-1:0] LAST_CNT = `MDU_XLEN - 1;

  mdu_state_e             state_q;
  mdu_state_e             state_d;
  logic [`MDU_CNT_W-1:0]  cnt_q;
  logic                   special;
  logic                   last_step;

  assign special   = ops_i.div_by_zero | ops_i.div_overflow;
  assign last_step = (cnt_q == LAST_CNT);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // iteration counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (load_o) begin
      cnt_q <= '0;
    end else if (step_o) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (valid_i) begin
          state_d = LOAD;
        end
      end
      LOAD: begin
        if (special) begin
          state_d = FIX; // result is a fixed value
        end else begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (last_step) begin
          state_d = FIX;
        end
      end
      FIX: state_d = DONE;
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign start_o  = (state_q == IDLE) & valid_i; // requests while busy are dropped
  assign load_o   = (state_q == LOAD) & ~special;
  assign step_o   = (state_q == RUN);
  assign fix_en_o = (state_q == FIX);
  assign done_o   = (state_q == DONE);
  assign state_o  = state_q;

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) done_o |=> !done_o
  );

endmodule

// ==== src/mdu_result_fix.sv ====
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_result_fix import mdu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fix_en_i,
  input  mdu_operands_t          ops_i,
  input  mdu_op_e                op_i,
  input  mdu_state_e             state_i,
  input  logic [2*`MDU_XLEN-1:0] product_i,
  input  logic [`MDU_XLEN-1:0]   quot_i,
  input  logic [`MDU_XLEN-1:0]   rem_i,
  output logic [`MDU_XLEN-1:0]   result_o,
  output logic                   div_by_zero_o,
  output logic                   div_overflow_o
);

  mdu_op_e                op_q;
  logic [2*`MDU_XLEN-1:0] prod_fix;
  logic [`MDU_XLEN-1:0]   quot_fix;
  logic [`MDU_XLEN-1:0]   rem_fix;
  logic [`MDU_XLEN-1:0]   rs1_back; // rs1 rebuilt from its magnitude
  logic [`MDU_XLEN-1:0]   result_d;

  function automatic logic [`MDU_XLEN-1:0] cond_neg(input logic neg,
                                                     input logic [`MDU_XLEN-1:0] val);
    return neg ? -val : val;
  endfunction

  // last idle cycle is the accepting one
  always_ff @(posedge clk) begin
    if (state_i == IDLE) begin
      op_q <= op_i;
    end
  end

  assign prod_fix = ops_i.neg_main ? -product_i : product_i;
  assign quot_fix = cond_neg(ops_i.neg_main, quot_i);
  assign rem_fix  = cond_neg(ops_i.neg_rem, rem_i);
  assign rs1_back = cond_neg(ops_i.neg_rem, ops_i.mag_a);

  always_comb begin
    if (!ops_i.is_div) begin
      if (op_q == OP_MUL) begin
        result_d = prod_fix[`MDU_XLEN-1:0];
      end else begin
        result_d = prod_fix[2*`MDU_XLEN-1:`MDU_XLEN];
      end
    end else if (op_q == OP_DIV || op_q == OP_DIVU) begin
      if (ops_i.div_by_zero) begin
        result_d = `MDU_ALL_ONES;
      end else if (ops_i.div_overflow) begin
        result_d = `MDU_INT_MIN;
      end else begin
        result_d = quot_fix;
      end
    end else begin
      if (ops_i.div_by_zero) begin
        result_d = rs1_back;
      end else if (ops_i.div_overflow) begin
        result_d = '0;
      end else begin
        result_d = rem_fix;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_o       <= '0;
      div_by_zero_o  <= 1'b0;
      div_overflow_o <= 1'b0;
    end else if (fix_en_i) begin
      result_o       <= result_d;
      div_by_zero_o  <= ops_i.div_by_zero;
      div_overflow_o <= ops_i.div_overflow;
    end
  end

  a_flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(div_by_zero_o && div_overflow_o)
  );

  a_fix_in_state: assert property (
    @(posedge clk) disable iff (!rst_n) fix_en_i |-> (state_i == FIX)
  );

endmodule

// ==== src/mdu_top.sv ====
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_top import mdu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 valid_i,
  input  mdu_req_t             req_i,
  output logic [`MDU_XLEN-1:0] result_o,
  output logic                 done_o,
  output logic                 div_by_zero_o,
  output logic                 div_overflow_o
);

  logic                   start;
  logic                   load;
  logic                   step;
  logic                   fix_en;
  mdu_state_e             state;
  mdu_operands_t          ops;
  logic [2*`MDU_XLEN-1:0] product;
  logic [`MDU_XLEN-1:0]   quot;
  logic [`MDU_XLEN-1:0]   rem;

  mdu_operand_prep prep0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start),
    .req_i   (req_i),
    .ops_o   (ops)
  );

  mdu_ctrl ctrl0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .ops_i    (ops),
    .start_o  (start),
    .load_o   (load),
    .step_o   (step),
    .fix_en_o (fix_en),
    .state_o  (state),
    .done_o   (done_o)
  );

  mdu_mul_core mul0 (
    .clk       (clk),
    .load_i    (load),
    .step_i    (step),
    .mag_a_i   (ops.mag_a),
    .mag_b_i   (ops.mag_b),
    .product_o (product)
  );

  mdu_div_core div0 (
    .clk     (clk),
    .load_i  (load),
    .step_i  (step),
    .mag_a_i (ops.mag_a),
    .mag_b_i (ops.mag_b),
    .quot_o  (quot),
    .rem_o   (rem)
  );

  // op is sampled inside while idle
  mdu_result_fix fix0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .fix_en_i       (fix_en),
    .ops_i          (ops),
    .op_i           (req_i.op),
    .state_i        (state),
    .product_i      (product),
    .quot_i         (quot),
    .rem_i          (rem),
    .result_o       (result_o),
    .div_by_zero_o  (div_by_zero_o),
    .div_overflow_o (div_overflow_o)
  );

endmodule

// ==== verif/mdu_clk_gen.sv ====
`timescale 1ns/1ns

module mdu_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o); // release away from the sampling edge
    rst_n_o = 1'b1;
  end

endmodule

// ==== verif/mdu_tb.sv ====
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_tb import mdu_pkg::*; ();

  localparam int MAX_TESTS      = 64;
  localparam int N_RANDOM       = 24;
  localparam int NORMAL_CYCLES  = `MDU_XLEN + 3;
  localparam int SPECIAL_CYCLES = 3;

  logic                 clk;
  logic                 rst_n;
  logic                 valid_i;
  mdu_req_t             req_i;
  logic [`MDU_XLEN-1:0] result_o;
  logic                 done_o;
  logic                 div_by_zero_o;
  logic                 div_overflow_o;

  logic [31:0] vec_mem [0:6*MAX_TESTS-1]; // six words per test
  integer      seed;
  int          n_file;
  int          n_pass;
  int          n_fail;
  int          errors;
  bit          loaded;

  mdu_clk_gen clk_gen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mdu_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .req_i          (req_i),
    .result_o       (result_o),
    .done_o         (done_o),
    .div_by_zero_o  (div_by_zero_o),
    .div_overflow_o (div_overflow_o)
  );

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // reference results for the unsigned ops
  function automatic logic [31:0] expect_unsigned(input logic [2:0] op, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    case (op)
      3'b000: return prod[31:0];
      3'b011: return prod[63:32];
      3'b101: return (b == 32'd0) ? 32'hffff_ffff : a / b;
      default: return (b == 32'd0) ? a : a % b;
    endcase
  endfunction

  // called on a falling edge with the unit idle
  task automatic run_test(input int idx, input logic [2:0] op, input logic [31:0] rs1,
                          input logic [31:0] rs2, input logic [31:0] exp_res,
                          input logic exp_dz, input logic exp_ov);
    int cycles;
    int errs_before;
    int limit;
    errs_before = errors;
    limit       = NORMAL_CYCLES + 5;
    req_i.op    = mdu_op_e'(op);
    req_i.rs1   = rs1;
    req_i.rs2   = rs2;
    valid_i     = 1'b1;
    @(negedge clk);
    valid_i = 1'b0;
    cycles  = 1;
    while (!done_o && cycles < limit) begin
      if (cycles == 4) begin
        // request while busy, must be dropped
        valid_i   = 1'b1;
        req_i.op  = OP_MULHU;
        req_i.rs1 = $random(seed);
        req_i.rs2 = $random(seed);
      end else begin
        valid_i = 1'b0;
      end
      @(negedge clk);
      cycles++;
    end
    valid_i = 1'b0;
    if (!done_o) begin
      $display("Test %0d: done_o did not arrive within %0d cycles", idx, limit);
      errors++;
    end else begin
      compare("result_o", exp_res, result_o);
      compare("div_by_zero_o", {31'b0, exp_dz}, {31'b0, div_by_zero_o});
      compare("div_overflow_o", {31'b0, exp_ov}, {31'b0, div_overflow_o});
      compare("done_o latency", 32'((exp_dz | exp_ov) ? SPECIAL_CYCLES : NORMAL_CYCLES),
              32'(cycles));
      @(negedge clk);
      compare("done_o", 32'd0, {31'b0, done_o}); // one cycle wide
    end
    if (errors == errs_before) begin
      n_pass++;
      $display("Test %0d op %0d rs1 %h rs2 %h passed", idx, op, rs1, rs2);
    end else begin
      n_fail++;
      $display("Test %0d op %0d rs1 %h rs2 %h failed", idx, op, rs1, rs2);
    end
  endtask

  // no stray done pulse and the last result kept while idle
  task automatic check_quiet(input logic [31:0] exp_res);
    int pulses;
    pulses = 0;
    repeat (NORMAL_CYCLES + 1) begin
      @(negedge clk);
      if (done_o) begin
        pulses++;
      end
    end
    compare("done_o pulse count", 32'd0, 32'(pulses));
    compare("result_o", exp_res, result_o);
  endtask

  initial begin
    logic [31:0] r;
    logic [2:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    seed    = 80;
    valid_i = 1'b0;
    req_i   = '0;
    errors  = 0;
    n_pass  = 0;
    n_fail  = 0;
    n_file  = 0;
    for (int i = 0; i < 6*MAX_TESTS; i++) begin
      vec_mem[i] = 32'hdead_0000 | 32'(i); // marks unused entries
    end
    $readmemh("verif/mdu_tests.txt", vec_mem);
    while (n_file < MAX_TESTS && vec_mem[6*n_file][31:16] != 16'hdead) begin
      n_file++;
    end
    loaded = 1'b1;
    @(posedge rst_n);
    @(negedge clk);
    for (int t = 0; t < n_file; t++) begin
      run_test(t, vec_mem[6*t][2:0], vec_mem[6*t+1], vec_mem[6*t+2], vec_mem[6*t+3],
               vec_mem[6*t+4][0], vec_mem[6*t+5][0]);
      if (t == 0) begin
        check_quiet(vec_mem[3]);
      end
    end
    for (int t = 0; t < N_RANDOM; t++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0: op = 3'b000;
        2'd1: op = 3'b011;
        2'd2: op = 3'b101;
        default: op = 3'b111;
      endcase
      a = $random(seed);
      b = $random(seed);
      b = b >> r[12:8]; // smaller divisors give wider quotients
      run_test(n_file + t, op, a, b, expect_unsigned(op, a, b), op[2] && (b == 32'd0), 1'b0);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d mismatches", n_file + N_RANDOM, n_pass,
             n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    #(((n_file + N_RANDOM) * (`MDU_XLEN + 8) + 40) * 100);
    $display("Timeout: done_o never arrived, run stopped");
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
src/mdu_pkg.sv
src/mdu_mul_core.sv
src/mdu_div_core.sv
src/mdu_operand_prep.sv
src/mdu_ctrl.sv
src/mdu_result_fix.sv
src/mdu_top.sv
verif/mdu_clk_gen.sv
verif/mdu_tb.sv

// ==== Makefile ====
TOP = mdu_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Simulation completed successfully" sim.log

obj_dir/V$(TOP): build.f $(wildcard src/*.sv verif/*.sv include/*.svh verif/*.txt)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module mdu_top

clean:
	rm -rf obj_dir sim.log

// ==== verif/mdu_tests.txt ====
// op rs1 rs2 result div_by_zero div_overflow, all hex
// op is funct3: 0 mul, 1 mulh, 2 mulhsu, 3 mulhu, 4 div, 5 divu, 6 rem, 7 remu
0 00000007 00000006 0000002a 0 0
0 fffffffd 00000005 fffffff1 0 0
1 fffffffd 00000005 ffffffff 0 0
1 80000000 80000000 40000000 0 0
0 80000000 80000000 00000000 0 0
2 ffffffff ffffffff ffffffff 0 0
3 ffffffff ffffffff fffffffe 0 0
4 00000007 00000002 00000003 0 0
4 fffffff9 00000002 fffffffd 0 0
4 00000007 fffffffe fffffffd 0 0
4 fffffff9 fffffffe 00000003 0 0
6 00000007 00000002 00000001 0 0
6 fffffff9 00000002 ffffffff 0 0
6 00000007 fffffffe 00000001 0 0
6 fffffff9 fffffffe ffffffff 0 0
4 fffffff9 00000000 ffffffff 1 0
6 fffffff9 00000000 fffffff9 1 0
0 fffffff9 00000000 00000000 0 0
4 80000000 ffffffff 80000000 0 1
6 80000000 ffffffff 00000000 0 1
5 80000000 ffffffff 00000000 0 0
